// File: logic/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ====================
// Datapath widths
// ====================

// Width of every operand, immediate and program counter value
`define EX_NB 32

// Register file address width, 32 registers
`define EX_NB_REGS 5

// ====================
// Instruction fields
// ====================

// Primary opcode, bits 31:26 of the instruction word
`define EX_NB_OPCODE 6

// Funct field of R-type instructions, bits 5:0
`define EX_NB_FCODE 6

// ====================
// Memory access
// ====================

// Encoded access size handed on to the memory stage
`define EX_NB_SIZE 3

`endif

// File: logic/isa_pkg.sv
`default_nettype none

`include "ex_defines.svh"

package isa_pkg;

    // ====================
    // Instruction encodings
    // ====================

    typedef enum logic [`EX_NB_OPCODE-1:0] {
        OP_R_TYPE = 6'h00,   // Operation selected by funct
        OP_J      = 6'h02,
        OP_JAL    = 6'h03,   // Links into register 31
        OP_BEQ    = 6'h04,
        OP_BNE    = 6'h05,
        OP_ADDIU  = 6'h09,
        OP_SLTI   = 6'h0a,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_XORI   = 6'h0e,
        OP_LUI    = 6'h0f,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [`EX_NB_FCODE-1:0] {
        FN_SLL  = 6'h00,     // Shifts take their amount from shamt
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // ====================
    // Execute internals
    // ====================

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,             // Signed compare
        ALU_SLTU,            // Unsigned compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [`EX_NB_SIZE-1:0] {
        WS_BYTE = 3'b001,
        WS_HALF = 3'b010,
        WS_WORD = 3'b100
    } word_size_e;

endpackage

`default_nettype wire

// File: logic/stage_bus_pkg.sv
`default_nettype none

`include "ex_defines.svh"

package stage_bus_pkg;

    // Decoded instruction as it leaves the decode stage
    typedef struct packed {
        isa_pkg::opcode_e            opcode;
        isa_pkg::funct_e             funct;
        logic                        alu_src;          // Operand B from the immediate
        logic [`EX_NB-1:0]           data_a;
        logic [`EX_NB-1:0]           data_b;
        logic [`EX_NB-1:0]           shamt;
        logic [`EX_NB-1:0]           extension_result;
        logic [`EX_NB-1:0]           pc4;
        logic [`EX_NB-1:0]           jump_addr;
        logic                        branch;
        logic                        jump;
        logic                        jr_jalr;
        isa_pkg::word_size_e         word_size;
        logic                        is_signed;        // Sign-extend on load
        logic                        mem_read;
        logic                        mem_write;
        logic                        mem_to_reg;
        logic                        reg_write;
        logic [`EX_NB_REGS-1:0]      reg_dir_to_write;
        logic [`EX_NB_REGS-1:0]      dir_rs;           // Kept for forwarding
        logic [`EX_NB_REGS-1:0]      dir_rt;
        logic                        halt;
    } id_ex_t;

    typedef struct packed {
        logic                        taken;
        logic [`EX_NB-1:0]           target;
    } branch_res_t;

    typedef struct packed {
        logic [`EX_NB-1:0]           alu_result;       // Also the memory address
        logic [`EX_NB-1:0]           store_data;
        logic [`EX_NB-1:0]           wb_data;
        logic [`EX_NB_REGS-1:0]      reg_dir_to_write;
        isa_pkg::word_size_e         word_size;
        logic                        is_signed;
        logic                        mem_read;
        logic                        mem_write;
        logic                        mem_to_reg;
        logic                        reg_write;
        branch_res_t                 redirect;
        logic                        halt;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: logic/stage_register.sv
`timescale 1ns/1ps
`default_nettype none

module stage_register #(
    parameter type PAYLOAD_T = logic
) (
    input  wire logic     i_clk,
    input  wire logic     i_reset,
    input  wire logic     i_step,      // Global single-step enable
    // Upstream side
    input  wire logic     i_valid,
    output logic          o_ready,
    input  wire PAYLOAD_T i_data,
    // Downstream side
    output logic          o_valid,
    input  wire logic     i_ready,
    output PAYLOAD_T      o_data
);

    logic     valid_q;
    PAYLOAD_T data_q;
    logic     load;
    logic     drain;

    // ====================
    // Handshake
    // ====================

    // Room for a new item when empty or when the current one leaves now
    assign o_ready = i_step && (!valid_q || i_ready);
    assign load    = i_valid && o_ready;
    assign drain   = i_step && valid_q && i_ready;   // Held item goes downstream

    // ====================
    // Storage
    // ====================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;                          // Refill wins over drain
            data_q  <= i_data;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module alu_unit (
    input  wire stage_bus_pkg::id_ex_t i_id_ex,
    output logic [`EX_NB-1:0]          o_alu_result
);

    isa_pkg::alu_op_e  alu_op;
    logic [`EX_NB-1:0] operand_a;
    logic [`EX_NB-1:0] operand_b;
    logic [4:0]        shift_amount;

    // ====================
    // Operation decode
    // ====================

    always_comb begin
        alu_op = isa_pkg::ALU_ADD;                    // Loads, stores and jumps add
        case (i_id_ex.opcode)
            isa_pkg::OP_R_TYPE: begin
                case (i_id_ex.funct)
                    isa_pkg::FN_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLTU: alu_op = isa_pkg::ALU_SLTU;
                    isa_pkg::FN_SLL:  alu_op = isa_pkg::ALU_SLL;
                    isa_pkg::FN_SRL:  alu_op = isa_pkg::ALU_SRL;
                    isa_pkg::FN_SRA:  alu_op = isa_pkg::ALU_SRA;
                    default:          alu_op = isa_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OP_SLTI: alu_op = isa_pkg::ALU_SLT;
            isa_pkg::OP_ANDI: alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_ORI:  alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_XORI: alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_LUI:  alu_op = isa_pkg::ALU_LUI;
            isa_pkg::OP_BEQ,
            isa_pkg::OP_BNE:  alu_op = isa_pkg::ALU_SUB;  // Difference of the compared pair
            default:          alu_op = isa_pkg::ALU_ADD;
        endcase
    end

    // ====================
    // Datapath
    // ====================

    assign operand_a    = i_id_ex.data_a;
    assign operand_b    = i_id_ex.alu_src ? i_id_ex.extension_result : i_id_ex.data_b;
    assign shift_amount = i_id_ex.shamt[4:0];

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_SUB:  o_alu_result = operand_a - operand_b;
            isa_pkg::ALU_AND:  o_alu_result = operand_a & operand_b;
            isa_pkg::ALU_OR:   o_alu_result = operand_a | operand_b;
            isa_pkg::ALU_XOR:  o_alu_result = operand_a ^ operand_b;
            isa_pkg::ALU_NOR:  o_alu_result = ~(operand_a | operand_b);
            isa_pkg::ALU_SLT:
                o_alu_result = {{(`EX_NB-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            isa_pkg::ALU_SLTU:
                o_alu_result = {{(`EX_NB-1){1'b0}}, operand_a < operand_b};
            isa_pkg::ALU_SLL:  o_alu_result = operand_b << shift_amount;
            isa_pkg::ALU_SRL:  o_alu_result = operand_b >> shift_amount;
            isa_pkg::ALU_SRA:  o_alu_result = $signed(operand_b) >>> shift_amount;
            isa_pkg::ALU_LUI:  o_alu_result = {i_id_ex.extension_result[15:0], 16'h0000};
            default:           o_alu_result = operand_a + operand_b;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module branch_resolver (
    input  wire stage_bus_pkg::id_ex_t i_id_ex,
    output stage_bus_pkg::branch_res_t o_branch_res
);

    logic              operands_equal;
    logic              branch_cond;
    logic [`EX_NB-1:0] branch_target;

    // ====================
    // Conditional branches
    // ====================

    assign operands_equal = (i_id_ex.data_a == i_id_ex.data_b);

    // Word offset relative to the instruction after the branch
    assign branch_target = i_id_ex.pc4 + {i_id_ex.extension_result[`EX_NB-3:0], 2'b00};

    always_comb begin
        case (i_id_ex.opcode)
            isa_pkg::OP_BEQ: branch_cond = operands_equal;
            isa_pkg::OP_BNE: branch_cond = !operands_equal;
            default:         branch_cond = 1'b0;
        endcase
    end

    // ====================
    // Redirect select
    // ====================

    always_comb begin
        o_branch_res = '0;                            // No redirect, zero target
        if (i_id_ex.jr_jalr) begin
            o_branch_res.taken  = 1'b1;
            o_branch_res.target = i_id_ex.data_a;     // Register-indirect jump
        end else if (i_id_ex.jump) begin
            o_branch_res.taken  = 1'b1;
            o_branch_res.target = i_id_ex.jump_addr;
        end else if (i_id_ex.branch && branch_cond) begin
            o_branch_res.taken  = 1'b1;
            o_branch_res.target = branch_target;
        end
    end

endmodule

`default_nettype wire

// File: logic/result_merger.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module result_merger (
    input  wire stage_bus_pkg::id_ex_t      i_id_ex,
    input  wire logic [`EX_NB-1:0]          i_alu_result,
    input  wire stage_bus_pkg::branch_res_t i_branch_res,
    output stage_bus_pkg::ex_mem_t          o_ex_mem
);

    localparam logic [`EX_NB_REGS-1:0] LINK_REG = 31;

    logic is_jal;
    logic is_jalr;

    assign is_jal  = (i_id_ex.opcode == isa_pkg::OP_JAL);
    assign is_jalr = (i_id_ex.opcode == isa_pkg::OP_R_TYPE)
                  && (i_id_ex.funct == isa_pkg::FN_JALR);

    always_comb begin
        o_ex_mem.alu_result = i_alu_result;
        o_ex_mem.store_data = i_id_ex.data_b;              // rt value for SW
        o_ex_mem.wb_data    = (is_jal || is_jalr) ? i_id_ex.pc4 : i_alu_result;

        // No delay slot, so the link address is pc4 itself
        o_ex_mem.reg_dir_to_write = is_jal ? LINK_REG : i_id_ex.reg_dir_to_write;

        o_ex_mem.word_size  = i_id_ex.word_size;
        o_ex_mem.is_signed  = i_id_ex.is_signed;
        o_ex_mem.mem_read   = i_id_ex.mem_read;
        o_ex_mem.mem_write  = i_id_ex.mem_write;
        o_ex_mem.mem_to_reg = i_id_ex.mem_to_reg;
        o_ex_mem.reg_write  = i_id_ex.reg_write;
        o_ex_mem.redirect   = i_branch_res;
        o_ex_mem.halt       = i_id_ex.halt;                // Halt rides with its instruction
    end

endmodule

`default_nettype wire

// File: logic/ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage_top (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire logic                   i_step,
    // From decode
    input  wire stage_bus_pkg::id_ex_t  i_id_ex,
    input  wire logic                   i_valid,
    output logic                        o_ready,
    // To memory
    output stage_bus_pkg::ex_mem_t      o_ex_mem,
    output logic                        o_valid,
    input  wire logic                   i_ready
);

    stage_bus_pkg::id_ex_t      id_ex_q;
    logic                       id_ex_valid;
    logic                       ex_mem_ready;
    logic [`EX_NB-1:0]          alu_result;
    stage_bus_pkg::branch_res_t branch_res;
    stage_bus_pkg::ex_mem_t     ex_mem_d;

    // ====================
    // ID/EX register
    // ====================

    stage_register #(
        .PAYLOAD_T (stage_bus_pkg::id_ex_t)
    ) u_id_ex (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_step  (i_step),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (i_id_ex),
        .o_valid (id_ex_valid),
        .i_ready (ex_mem_ready),
        .o_data  (id_ex_q)
    );

    // ====================
    // Execute
    // ====================

    alu_unit u_alu (
        .i_id_ex      (id_ex_q),
        .o_alu_result (alu_result)
    );

    branch_resolver u_branch (
        .i_id_ex      (id_ex_q),
        .o_branch_res (branch_res)
    );

    result_merger u_merge (
        .i_id_ex      (id_ex_q),
        .i_alu_result (alu_result),
        .i_branch_res (branch_res),
        .o_ex_mem     (ex_mem_d)
    );

    // ====================
    // EX/MEM register
    // ====================

    stage_register #(
        .PAYLOAD_T (stage_bus_pkg::ex_mem_t)
    ) u_ex_mem (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_step  (i_step),
        .i_valid (id_ex_valid),                // Execute is purely combinational
        .o_ready (ex_mem_ready),
        .i_data  (ex_mem_d),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_ex_mem)
    );

endmodule

`default_nettype wire

// File: sim/ex_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_checker (
    input wire logic                   i_clk,
    input wire logic                   i_reset,
    input wire logic                   i_step,
    input wire logic                   i_ready,
    input wire logic                   i_out_valid,
    input wire stage_bus_pkg::ex_mem_t i_out_data
);

    int unsigned reset_fails = 0;
    int unsigned hold_fails  = 0;
    int unsigned step_fails  = 0;
    int unsigned fail_count;

    assign fail_count = reset_fails + hold_fails + step_fails;

    a_reset_empty: assert property (@(posedge i_clk) i_reset |=> !i_out_valid)
        else begin
            reset_fails++;
            $error("EX/MEM valid set right after a reset cycle");
        end

    // A held output must not move until the consumer takes it
    a_hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_out_valid && !i_ready |=> i_out_valid && $stable(i_out_data))
        else begin
            hold_fails++;
            $error("EX/MEM payload changed under back-pressure");
        end

    a_step_frozen: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_step && i_out_valid |=> i_out_valid && $stable(i_out_data))
        else begin
            step_fails++;
            $error("EX/MEM item left or changed while the step gate was low");
        end

endmodule

bind ex_stage_top ex_stage_checker u_checker (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_step      (i_step),
    .i_ready     (i_ready),
    .i_out_valid (o_valid),
    .i_out_data  (o_ex_mem)
);

`default_nettype wire

// File: sim/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb;

    localparam int WAIT_LIMIT = 60;

    typedef struct packed {
        stage_bus_pkg::id_ex_t  in;
        logic [`EX_NB-1:0]      exp_alu;
        logic [`EX_NB-1:0]      exp_wb;
        logic                   exp_taken;
        logic [`EX_NB-1:0]      exp_target;
        logic [`EX_NB_REGS-1:0] exp_rd;
    } vec_t;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_step;
    stage_bus_pkg::id_ex_t  i_id_ex;
    logic                   i_valid;
    logic                   o_ready;
    stage_bus_pkg::ex_mem_t o_ex_mem;
    logic                   o_valid;
    logic                   i_ready;

    vec_t                   vectors[$];
    vec_t                   exp_q[$];
    int                     stamp_q[$];
    vec_t                   cur_vec;
    stage_bus_pkg::ex_mem_t frozen;
    int                     cycle;
    int                     sent;
    int                     outputs;
    int                     value_errors;
    int                     proto_errors;
    int                     timeouts;
    logic                   random_ready;
    logic                   check_latency;
    logic                   saw_full;

    ex_stage_top i_ex_stage_top (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_step   (i_step),
        .i_id_ex  (i_id_ex),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .o_ex_mem (o_ex_mem),
        .o_valid  (o_valid),
        .i_ready  (i_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ====================
    // Stimulus table
    // ====================

    // Branch, jump and memory flags follow from the opcode as decode would set them
    function automatic void add_vec(isa_pkg::opcode_e op, isa_pkg::funct_e fn, logic src,
                                    logic [`EX_NB-1:0] a, logic [`EX_NB-1:0] b,
                                    logic [`EX_NB-1:0] imm, logic [`EX_NB-1:0] exp_alu,
                                    logic exp_taken, logic [`EX_NB-1:0] exp_target);
        vec_t v;
        logic is_jal;
        logic is_jalr;
        int   row;
        v = '0;
        row     = vectors.size();
        is_jal  = (op == isa_pkg::OP_JAL);
        is_jalr = (op == isa_pkg::OP_R_TYPE) && (fn == isa_pkg::FN_JALR);
        v.in.opcode           = op;
        v.in.funct            = fn;
        v.in.alu_src          = src;
        v.in.data_a           = a;
        v.in.data_b           = b;
        v.in.shamt            = imm;
        v.in.extension_result = imm;
        v.in.jump_addr        = imm;
        v.in.pc4              = 32'h100 + 32'(4 * row);
        v.in.branch           = (op == isa_pkg::OP_BEQ) || (op == isa_pkg::OP_BNE);
        v.in.jump             = (op == isa_pkg::OP_J) || is_jal;
        v.in.jr_jalr          = (op == isa_pkg::OP_R_TYPE) && (fn == isa_pkg::FN_JR || is_jalr);
        // Size and sign cycle per row so every code passes through
        v.in.word_size        = (row % 3 == 0) ? isa_pkg::WS_BYTE
                              : (row % 3 == 1) ? isa_pkg::WS_HALF : isa_pkg::WS_WORD;
        v.in.is_signed        = (row % 2 == 1);
        v.in.mem_read         = (op == isa_pkg::OP_LW);
        v.in.mem_to_reg       = (op == isa_pkg::OP_LW);
        v.in.mem_write        = (op == isa_pkg::OP_SW);
        v.in.reg_write        = !(v.in.mem_write || v.in.branch || op == isa_pkg::OP_J
                                  || (v.in.jr_jalr && !is_jalr));
        v.in.reg_dir_to_write = 5'd8;
        v.exp_alu             = exp_alu;
        v.exp_wb              = (is_jal || is_jalr) ? v.in.pc4 : exp_alu;  // Link value
        v.exp_taken           = exp_taken;
        v.exp_target          = exp_target;
        v.exp_rd              = is_jal ? 5'd31 : 5'd8;
        vectors.push_back(v);
    endfunction

    // I-type rows pass FN_SLL as a filler funct
    task automatic build_table();
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_ADDU, 1'b0, 'h7, 'h5, 0, 'hc, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SUBU, 1'b0, 'h5, 'h7, 0, 'hffff_fffe, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_AND, 1'b0, 'hf0f0, 'hff00, 0, 'hf000, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_OR, 1'b0, 'hf0f0, 'h0f00, 0, 'hfff0, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_XOR, 1'b0, 'hf0f0, 'hff00, 0, 'h0ff0, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_NOR, 1'b0, 'hff, 'hf00, 0, 'hffff_f000, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SLT, 1'b0, 'hffff_fff0, 'h5, 0, 'h1, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SLTU, 1'b0, 'hffff_fff0, 'h5, 0, 'h0, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SLL, 1'b0, 0, 'h3, 'h4, 'h30, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SRL, 1'b0, 0, 'h8000_0000, 'h4,
                'h0800_0000, 1'b0, 0);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_SRA, 1'b0, 0, 'h8000_0000, 'h4,
                'hf800_0000, 1'b0, 0);
        add_vec(isa_pkg::OP_ADDIU, isa_pkg::FN_SLL, 1'b1, 'ha, 0, 'hffff_fffc, 'h6, 1'b0, 0);
        add_vec(isa_pkg::OP_SLTI, isa_pkg::FN_SLL, 1'b1, 'hffff_fffe, 0, 'h1, 'h1, 1'b0, 0);
        add_vec(isa_pkg::OP_ANDI, isa_pkg::FN_SLL, 1'b1, 'h1234, 0, 'hff, 'h34, 1'b0, 0);
        add_vec(isa_pkg::OP_ORI, isa_pkg::FN_SLL, 1'b1, 'h1200, 0, 'h34, 'h1234, 1'b0, 0);
        add_vec(isa_pkg::OP_XORI, isa_pkg::FN_SLL, 1'b1, 'hff, 0, 'hf0, 'hf, 1'b0, 0);
        add_vec(isa_pkg::OP_LUI, isa_pkg::FN_SLL, 1'b1, 0, 0, 'h1234, 'h1234_0000, 1'b0, 0);
        add_vec(isa_pkg::OP_LW, isa_pkg::FN_SLL, 1'b1, 'h1000, 0, 'h8, 'h1008, 1'b0, 0);
        add_vec(isa_pkg::OP_SW, isa_pkg::FN_SLL, 1'b1, 'h2000, 0, 'hffff_fffc, 'h1ffc, 1'b0, 0);
        add_vec(isa_pkg::OP_BEQ, isa_pkg::FN_SLL, 1'b0, 'h55, 'h55, 'h3, 0, 1'b1, 'h158);
        add_vec(isa_pkg::OP_BEQ, isa_pkg::FN_SLL, 1'b0, 'h1, 'h2, 'h3, 'hffff_ffff, 1'b0, 0);
        add_vec(isa_pkg::OP_BNE, isa_pkg::FN_SLL, 1'b0, 'h9, 'h9, 'h3, 0, 1'b0, 0);
        add_vec(isa_pkg::OP_BNE, isa_pkg::FN_SLL, 1'b0, 'h1, 'h2, 'hffff_fffe,
                'hffff_ffff, 1'b1, 'h150);                   // Backward branch
        add_vec(isa_pkg::OP_J, isa_pkg::FN_SLL, 1'b0, 0, 0, 'h200, 0, 1'b1, 'h200);
        add_vec(isa_pkg::OP_JAL, isa_pkg::FN_SLL, 1'b0, 0, 0, 'h0040_0000, 0, 1'b1,
                'h0040_0000);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_JR, 1'b0, 'h400, 0, 0, 'h400, 1'b1, 'h400);
        add_vec(isa_pkg::OP_R_TYPE, isa_pkg::FN_JALR, 1'b0, 'h800, 0, 0, 'h800, 1'b1, 'h800);
    endtask

    // ====================
    // Driving
    // ====================

    always @(posedge i_clk) begin
        #1;
        i_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
    end

    task automatic send(input int idx);
        int waited;
        cur_vec = vectors[idx];
        if (cur_vec.in.alu_src)
            cur_vec.in.data_b = $urandom;                    // Must not reach the ALU
        // Fields this instruction does not use carry noise
        if (!cur_vec.in.alu_src && !cur_vec.in.branch)
            cur_vec.in.extension_result = $urandom;
        if (!cur_vec.in.jump)
            cur_vec.in.jump_addr = $urandom;
        if (cur_vec.in.opcode != isa_pkg::OP_R_TYPE
                || !(cur_vec.in.funct inside {isa_pkg::FN_SLL, isa_pkg::FN_SRL,
                                              isa_pkg::FN_SRA}))
            cur_vec.in.shamt = $urandom;
        cur_vec.in.halt = (idx % 7 == 6);
        i_id_ex = cur_vec.in;
        i_valid = 1'b1;
        sent++;
        waited = 0;
        @(posedge i_clk);
        while (!o_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge i_clk);
        end
        assert (o_ready) else begin
            timeouts++;
            $display("Entry %0d was not accepted within %0d cycles", idx, WAIT_LIMIT);
        end
        #1;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            timeouts++;
            $display("%0d items still in the pipeline after %0d cycles", exp_q.size(),
                     WAIT_LIMIT);
        end
    endtask

    // ====================
    // Checking
    // ====================

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_output();
        vec_t e;
        int   st;
        if (exp_q.size() == 0) begin
            proto_errors++;
            $display("Output transfer at %0t with nothing accepted", $time);
            return;
        end
        e  = exp_q.pop_front();
        st = stamp_q.pop_front();
        outputs++;
        check_word("alu_result", e.exp_alu, o_ex_mem.alu_result);
        check_word("wb_data", e.exp_wb, o_ex_mem.wb_data);
        check_word("store_data", e.in.data_b, o_ex_mem.store_data);
        check_word("reg_dir_to_write", 32'(e.exp_rd), 32'(o_ex_mem.reg_dir_to_write));
        check_word("redirect.taken", 32'(e.exp_taken), 32'(o_ex_mem.redirect.taken));
        check_word("redirect.target", e.exp_target, o_ex_mem.redirect.target);
        check_word("mem_read", 32'(e.in.mem_read), 32'(o_ex_mem.mem_read));
        check_word("mem_write", 32'(e.in.mem_write), 32'(o_ex_mem.mem_write));
        check_word("mem_to_reg", 32'(e.in.mem_to_reg), 32'(o_ex_mem.mem_to_reg));
        check_word("reg_write", 32'(e.in.reg_write), 32'(o_ex_mem.reg_write));
        check_word("word_size", 32'(e.in.word_size), 32'(o_ex_mem.word_size));
        check_word("is_signed", 32'(e.in.is_signed), 32'(o_ex_mem.is_signed));
        check_word("halt", 32'(e.in.halt), 32'(o_ex_mem.halt));
        if (check_latency) begin
            assert (cycle - st == 2) else begin
                proto_errors++;
                $display("Item left %0d edges after it was accepted instead of 2", cycle - st);
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (exp_q.size() == 2 && !i_ready && i_step) begin
                saw_full = 1'b1;                             // Both stages hold an item
                check_word("o_ready", 32'd0, 32'(o_ready));
            end
            if (o_valid && i_ready && i_step)
                check_output();
            if (i_valid && o_ready) begin
                exp_q.push_back(cur_vec);
                stamp_q.push_back(cycle);
            end
        end
        cycle++;
    end

    initial begin
        void'($urandom(32'h633c));
        i_reset       = 1'b1;
        i_step        = 1'b1;
        i_valid       = 1'b0;
        i_id_ex       = '0;
        i_ready       = 1'b1;
        random_ready  = 1'b0;
        check_latency = 1'b0;
        saw_full      = 1'b0;
        cycle         = 0;
        sent          = 0;
        outputs       = 0;
        value_errors  = 0;
        proto_errors  = 0;
        timeouts      = 0;
        build_table();
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_word("o_valid", 32'd0, 32'(o_valid));
        check_word("o_ready", 32'd1, 32'(o_ready));
        assert (o_ex_mem === '0) else begin
            value_errors++;
            $display("ERR %0t o_ex_mem expected 0 got %h", $time, o_ex_mem);
        end

        // Full throughput, fixed two-edge latency
        check_latency = 1'b1;
        foreach (vectors[i]) begin
            send(i);
        end
        i_valid = 1'b0;
        wait_drained();
        check_latency = 1'b0;

        random_ready <= 1'b1;
        foreach (vectors[i]) begin
            send(i);
        end
        i_valid = 1'b0;
        random_ready <= 1'b0;
        wait_drained();

        // Freeze with both stages full, then release
        send(5);
        send(6);
        i_valid = 1'b0;
        i_step  = 1'b0;
        frozen  = o_ex_mem;
        repeat (5) begin
            @(posedge i_clk);
            check_word("o_valid", 32'd1, 32'(o_valid));
            check_word("o_ready", 32'd0, 32'(o_ready));
            assert (o_ex_mem === frozen) else begin
                value_errors++;
                $display("ERR %0t o_ex_mem expected %h got %h", $time, frozen, o_ex_mem);
            end
        end
        #1;
        i_step = 1'b1;
        wait_drained();

        assert (saw_full) else begin
            proto_errors++;
            $display("Back-pressure never filled both stages");
        end
        $display("Outputs %0d of %0d, value errors %0d, protocol errors %0d, timeouts %0d, %s %0d",
                 outputs, sent, value_errors, proto_errors, timeouts, "assertion failures",
                 i_ex_stage_top.u_checker.fail_count);
        if (value_errors == 0 && proto_errors == 0 && timeouts == 0 && outputs == sent
                && i_ex_stage_top.u_checker.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/isa_pkg.sv
logic/stage_bus_pkg.sv
logic/stage_register.sv
logic/alu_unit.sv
logic/branch_resolver.sv
logic/result_merger.sv
logic/ex_stage_top.sv
sim/ex_stage_checker.sv
sim/ex_stage_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module ex_stage_tb -o ex_stage_sim
	./obj_dir/ex_stage_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
